// File: include/csr_settings.svh
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

// data word and csr address widths
`define XLEN   32
`define CSR_AW 12

// mcause codes with bit 31 as the interrupt flag
`define CAUSE_ECALL 32'h0000000B
`define CAUSE_MEXT  32'h8000000B

// mie bit for the machine external interrupt
`define MEIE_BIT 11

// width of the cycle counter
`define CYCLE_W 64

`endif

// File: source/csr_pkg.sv
`include "csr_settings.svh"

package csr_pkg;

    // machine-mode csr addresses handled here
    typedef enum logic [`CSR_AW-1:0] {
        CSR_MSTATUS  = 12'h300,
        CSR_MIE      = 12'h304,
        CSR_MTVEC    = 12'h305,
        CSR_MSCRATCH = 12'h340,
        CSR_MEPC     = 12'h341,
        CSR_MCAUSE   = 12'h342,
        CSR_CYCLE    = 12'hC00,
        CSR_CYCLEH   = 12'hC80
    } csr_addr_e;

    typedef enum logic [1:0] {
        CSR_NONE = 2'b00, // no command this cycle
        CSR_RW   = 2'b01,
        CSR_RS   = 2'b10,
        CSR_RC   = 2'b11
    } csr_op_e;

    // command from the execute stage
    typedef struct packed {
        csr_op_e           op;
        csr_addr_e         addr;
        logic [`XLEN-1:0]  operand; // rs1 or zero-extended uimm
    } csr_cmd_t;

    // one write request into the register file
    typedef struct packed {
        logic              we;
        csr_addr_e         addr;
        logic [`XLEN-1:0]  data;
    } csr_wr_t;

    typedef struct packed {
        logic [`XLEN-9:0] rsv_hi;
        logic             mpie;   // bit 7
        logic [2:0]       rsv_mid;
        logic             mie;    // bit 3
        logic [2:0]       rsv_lo;
    } mstatus_f_t;

    // mstatus seen either as a word or by field
    typedef union packed {
        logic [`XLEN-1:0] raw;
        mstatus_f_t       f;
    } mstatus_u;

endpackage

// File: source/csr_alu.sv
`timescale 1ns/10ps
`include "csr_settings.svh"

module csr_alu (
    input  csr_pkg::csr_cmd_t cmd_i,
    input  logic [`XLEN-1:0]  old_i,
    output logic [`XLEN-1:0]  rdata_o,
    output csr_pkg::csr_wr_t  wr_o
);

    logic              set_clr_en; // rs/rc only write with a nonzero mask
    logic [`XLEN-1:0]  new_val;

    assign set_clr_en = |cmd_i.operand;

    always_comb begin
        new_val = old_i;
        wr_o.we = 1'b0;
        case (cmd_i.op)
            csr_pkg::CSR_RW: begin
                new_val = cmd_i.operand;
                wr_o.we = 1'b1;
            end
            csr_pkg::CSR_RS: begin
                new_val = old_i | cmd_i.operand;
                wr_o.we = set_clr_en;
            end
            csr_pkg::CSR_RC: begin
                new_val = old_i & ~cmd_i.operand;
                wr_o.we = set_clr_en;
            end
            default: begin
                new_val = old_i;
                wr_o.we = 1'b0;
            end
        endcase
        wr_o.addr = cmd_i.addr;
        wr_o.data = new_val;
    end

    // instruction result is always the value before the write
    assign rdata_o = (cmd_i.op != csr_pkg::CSR_NONE) ? old_i : '0;

endmodule

// File: source/csr_file.sv
`timescale 1ns/10ps
`include "csr_settings.svh"

module csr_file (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  csr_pkg::csr_addr_e   ex_raddr_i,
    input  csr_pkg::csr_wr_t     ex_wr_i,
    input  csr_pkg::csr_wr_t     trap_wr_i,
    input  csr_pkg::csr_addr_e   trap_raddr_i,
    output logic [`XLEN-1:0]     ex_rdata_o,
    output logic [`XLEN-1:0]     trap_rdata_o,
    output logic [`XLEN-1:0]     mtvec_o,
    output logic [`XLEN-1:0]     mepc_o,
    output csr_pkg::mstatus_u    mstatus_o
);

    logic [`CYCLE_W-1:0] cycle;
    logic [`XLEN-1:0]    mtvec;
    logic [`XLEN-1:0]    mcause;
    logic [`XLEN-1:0]    mepc;
    logic [`XLEN-1:0]    mie;
    logic [`XLEN-1:0]    mscratch;
    csr_pkg::mstatus_u   mstatus;

    csr_pkg::csr_wr_t    wr; // the one write applied this cycle

    // ex port has priority
    assign wr = ex_wr_i.we ? ex_wr_i : trap_wr_i;

    // free running after reset release
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cycle <= '0;
        end else begin
            cycle <= cycle + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mtvec    <= '0;
            mcause   <= '0;
            mepc     <= '0;
            mie      <= '0;
            mscratch <= '0;
            mstatus  <= '0;
        end else if (wr.we) begin
            case (wr.addr)
                csr_pkg::CSR_MTVEC:    mtvec       <= wr.data;
                csr_pkg::CSR_MCAUSE:   mcause      <= wr.data;
                csr_pkg::CSR_MEPC:     mepc        <= wr.data;
                csr_pkg::CSR_MIE:      mie         <= wr.data;
                csr_pkg::CSR_MSCRATCH: mscratch    <= wr.data;
                csr_pkg::CSR_MSTATUS:  mstatus.raw <= wr.data;
                default: begin
                    // cycle counter and unknown addresses are read-only
                end
            endcase
        end
    end

    function automatic logic [`XLEN-1:0] read_csr(input csr_pkg::csr_addr_e addr);
        logic [`XLEN-1:0] val;
        case (addr)
            csr_pkg::CSR_CYCLE:    val = cycle[`XLEN-1:0];
            csr_pkg::CSR_CYCLEH:   val = cycle[`CYCLE_W-1:`XLEN];
            csr_pkg::CSR_MTVEC:    val = mtvec;
            csr_pkg::CSR_MCAUSE:   val = mcause;
            csr_pkg::CSR_MEPC:     val = mepc;
            csr_pkg::CSR_MIE:      val = mie;
            csr_pkg::CSR_MSCRATCH: val = mscratch;
            csr_pkg::CSR_MSTATUS:  val = mstatus.raw;
            default:               val = '0;
        endcase
        return val;
    endfunction

    // reads return the stored value without bypass
    always_comb begin
        ex_rdata_o = read_csr(ex_raddr_i);
    end

    always_comb begin
        trap_rdata_o = read_csr(trap_raddr_i);
    end

    assign mtvec_o   = mtvec;
    assign mepc_o    = mepc;
    assign mstatus_o = mstatus;

endmodule

// File: source/trap_ctrl.sv
`timescale 1ns/10ps
`include "csr_settings.svh"

module trap_ctrl (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 irq_i,       // level
    input  logic                 ecall_i,     // pulse
    input  logic                 mret_i,      // pulse
    input  logic [`XLEN-1:0]     pc_i,
    input  logic [`XLEN-1:0]     mie_i,
    input  logic [`XLEN-1:0]     mtvec_i,
    input  logic [`XLEN-1:0]     mepc_i,
    input  csr_pkg::mstatus_u    mstatus_i,
    output csr_pkg::csr_addr_e   mie_addr_o,
    output csr_pkg::csr_wr_t     wr_o,
    output logic                 hold_o,
    output logic                 redirect_o,
    output logic [`XLEN-1:0]     redirect_pc_o
);

    typedef enum logic [2:0] {
        IDLE,
        SAVE_EPC,
        SAVE_CAUSE,
        SAVE_STATUS,
        RET_STATUS,
        JUMP
    } state_e;

    state_e             state_q;
    state_e             state_d;
    logic               irq_take;
    logic               trap_take;
    logic [`XLEN-1:0]   epc_q;
    logic [`XLEN-1:0]   cause_q;
    logic               ret_q;       // jump target is mepc
    csr_pkg::mstatus_u  status_next;

    assign mie_addr_o = csr_pkg::CSR_MIE;

    assign irq_take  = irq_i && mstatus_i.f.mie && mie_i[`MEIE_BIT];
    assign trap_take = ecall_i || irq_take;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // sampled every idle cycle and frozen once a sequence starts
    always_ff @(posedge clk) begin
        if (state_q == IDLE) begin
            epc_q   <= pc_i;
            cause_q <= ecall_i ? `CAUSE_ECALL : `CAUSE_MEXT;
            ret_q   <= mret_i;
        end
    end

    always_comb begin
        status_next = mstatus_i;
        if (state_q == RET_STATUS) begin
            status_next.f.mie  = mstatus_i.f.mpie;
            status_next.f.mpie = 1'b1;
        end else begin
            status_next.f.mpie = mstatus_i.f.mie; // trap entry
            status_next.f.mie  = 1'b0;
        end
    end

    always_comb begin
        state_d   = state_q;
        wr_o.we   = 1'b0;
        wr_o.addr = csr_pkg::CSR_MSTATUS;
        wr_o.data = status_next.raw;
        case (state_q)
            IDLE: begin
                if (mret_i) state_d = RET_STATUS;
                else if (trap_take) state_d = SAVE_EPC;
            end
            SAVE_EPC: begin
                wr_o.we   = 1'b1;
                wr_o.addr = csr_pkg::CSR_MEPC;
                wr_o.data = epc_q;
                state_d   = SAVE_CAUSE;
            end
            SAVE_CAUSE: begin
                wr_o.we   = 1'b1;
                wr_o.addr = csr_pkg::CSR_MCAUSE;
                wr_o.data = cause_q;
                state_d   = SAVE_STATUS;
            end
            SAVE_STATUS, RET_STATUS: begin
                wr_o.we = 1'b1;
                state_d = JUMP;
            end
            default: state_d = IDLE; // JUMP
        endcase
    end

    assign hold_o        = (state_q != IDLE);
    assign redirect_o    = (state_q == JUMP);
    assign redirect_pc_o = ret_q ? mepc_i : mtvec_i;

endmodule

// File: source/csr_unit_top.sv
`timescale 1ns/10ps
`include "csr_settings.svh"

module csr_unit_top (
    input  logic               clk,
    input  logic               arst_n_i,
    input  csr_pkg::csr_cmd_t  cmd_i,
    input  logic [`XLEN-1:0]   pc_i,
    input  logic               irq_i,
    input  logic               ecall_i,
    input  logic               mret_i,
    output logic [`XLEN-1:0]   rdata_o,
    output logic               global_int_en_o,
    output logic               hold_o,
    output logic               redirect_o,
    output logic [`XLEN-1:0]   redirect_pc_o
);

    logic [`XLEN-1:0]    ex_old;
    csr_pkg::csr_wr_t    ex_wr;
    csr_pkg::csr_wr_t    trap_wr;
    csr_pkg::csr_addr_e  mie_addr;
    logic [`XLEN-1:0]    mie_val;
    logic [`XLEN-1:0]    mtvec;
    logic [`XLEN-1:0]    mepc;
    csr_pkg::mstatus_u   mstatus;

    assign global_int_en_o = mstatus.f.mie;

    csr_alu u_csr_alu (
        .cmd_i   (cmd_i),
        .old_i   (ex_old),
        .rdata_o (rdata_o),
        .wr_o    (ex_wr)
    );

    csr_file u_csr_file (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .ex_raddr_i   (cmd_i.addr),
        .ex_wr_i      (ex_wr),
        .trap_wr_i    (trap_wr),
        .trap_raddr_i (mie_addr), // second port only ever reads mie
        .ex_rdata_o   (ex_old),
        .trap_rdata_o (mie_val),
        .mtvec_o      (mtvec),
        .mepc_o       (mepc),
        .mstatus_o    (mstatus)
    );

    trap_ctrl u_trap_ctrl (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .irq_i         (irq_i),
        .ecall_i       (ecall_i),
        .mret_i        (mret_i),
        .pc_i          (pc_i),
        .mie_i         (mie_val),
        .mtvec_i       (mtvec),
        .mepc_i        (mepc),
        .mstatus_i     (mstatus),
        .mie_addr_o    (mie_addr),
        .wr_o          (trap_wr),
        .hold_o        (hold_o),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

endmodule

// File: test/csr_unit_tb.sv
`timescale 1ns/10ps
`include "csr_settings.svh"

module csr_unit_tb;

    typedef struct packed {
        csr_pkg::csr_op_e    op;
        logic [`CSR_AW-1:0]  addr;
        logic [`XLEN-1:0]    operand;
        logic                irq;
        logic                ecall;
        logic                mret;
        logic [`XLEN-1:0]    pc;
        int                  idle;
    } row_t;

    logic               clk;
    logic               arst_n_i;
    csr_pkg::csr_cmd_t  cmd_i;
    logic [`XLEN-1:0]   pc_i;
    logic               irq_i;
    logic               ecall_i;
    logic               mret_i;
    logic [`XLEN-1:0]   rdata_o;
    logic               global_int_en_o;
    logic               hold_o;
    logic               redirect_o;
    logic [`XLEN-1:0]   redirect_pc_o;

    row_t               rows[$];
    logic [`XLEN-1:0]   model [0:(1<<`CSR_AW)-1]; // expected csr contents by address
    int                 seed;
    int                 errors;
    int                 checks;
    int                 row_err;
    int                 edges;
    int                 limit;
    int                 prev_edges;
    logic [`XLEN-1:0]   prev_cyc;
    logic               have_cyc;

    csr_unit_top u_csr_unit_top (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .cmd_i           (cmd_i),
        .pc_i            (pc_i),
        .irq_i           (irq_i),
        .ecall_i         (ecall_i),
        .mret_i          (mret_i),
        .rdata_o         (rdata_o),
        .global_int_en_o (global_int_en_o),
        .hold_o          (hold_o),
        .redirect_o      (redirect_o),
        .redirect_pc_o   (redirect_pc_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        edges = edges + 1;
        if (limit != 0 && edges > limit) begin
            $display("timeout after %0d cycles", edges);
            $display("Regression failed");
            $finish;
        end
    end

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            errors++;
            row_err++;
            $display("FAILED %s exp %08h got %08h", name, exp, got);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            row_err++;
            $display("ERROR %s", what);
        end
    endtask

    function automatic logic writable(input logic [`CSR_AW-1:0] a);
        return a == csr_pkg::CSR_MSTATUS || a == csr_pkg::CSR_MIE || a == csr_pkg::CSR_MTVEC
            || a == csr_pkg::CSR_MSCRATCH || a == csr_pkg::CSR_MEPC || a == csr_pkg::CSR_MCAUSE;
    endfunction

    // model update by an execute command at the next edge
    task automatic apply_cmd(input row_t r);
        logic [`XLEN-1:0] old;
        old = model[r.addr];
        if (writable(r.addr)) begin
            if (r.op == csr_pkg::CSR_RW) model[r.addr] = r.operand;
            else if (r.op == csr_pkg::CSR_RS && r.operand != 0) model[r.addr] = old | r.operand;
            else if (r.op == csr_pkg::CSR_RC && r.operand != 0) model[r.addr] = old & ~r.operand;
        end
    endtask

    task automatic run_row(input row_t r, input int idx);
        int               k;
        int               exp_lat;
        logic [`XLEN-1:0] exp_pc;
        logic             take;
        row_err = 0;
        @(negedge clk);
        cmd_i.op      = r.op;
        cmd_i.addr    = csr_pkg::csr_addr_e'(r.addr);
        cmd_i.operand = r.operand;
        irq_i   = r.irq;
        ecall_i = r.ecall;
        mret_i  = r.mret;
        pc_i    = r.pc;
        #5;
        if (r.op != csr_pkg::CSR_NONE && r.addr == csr_pkg::CSR_CYCLE) begin
            if (have_cyc) check_val("cycle delta", edges - prev_edges, rdata_o - prev_cyc);
            prev_cyc   = rdata_o;
            prev_edges = edges;
            have_cyc   = 1'b1;
        end else if (r.op != csr_pkg::CSR_NONE) begin
            check_val("rdata_o", model[r.addr], rdata_o);
        end else begin
            check_val("rdata_o", 32'h0, rdata_o);
        end
        take = r.mret || r.ecall
            || (r.irq && model[csr_pkg::CSR_MSTATUS][3] && model[csr_pkg::CSR_MIE][`MEIE_BIT]);
        exp_lat = r.mret ? 2 : 4;
        exp_pc  = r.mret ? model[csr_pkg::CSR_MEPC] : model[csr_pkg::CSR_MTVEC];
        apply_cmd(r);
        @(negedge clk);
        cmd_i   = '0;
        ecall_i = 1'b0;
        mret_i  = 1'b0;
        if (take) irq_i = 1'b0; // masked irq stays up while gating is checked
        #5;
        if (take) begin
            k = 1;
            while (!redirect_o && k < 8) begin
                check_true(hold_o, "hold_o low during trap sequence");
                @(negedge clk);
                #5;
                k++;
            end
            check_true(redirect_o, "no redirect after trap or return request");
            check_val("redirect latency", exp_lat, k);
            check_val("redirect_pc_o", exp_pc, redirect_pc_o);
            check_true(hold_o, "hold_o low in redirect cycle");
            if (r.mret) begin
                model[csr_pkg::CSR_MSTATUS][3] = model[csr_pkg::CSR_MSTATUS][7];
                model[csr_pkg::CSR_MSTATUS][7] = 1'b1;
            end else begin
                model[csr_pkg::CSR_MEPC]       = r.pc;
                model[csr_pkg::CSR_MCAUSE]     = r.ecall ? `CAUSE_ECALL : `CAUSE_MEXT;
                model[csr_pkg::CSR_MSTATUS][7] = model[csr_pkg::CSR_MSTATUS][3];
                model[csr_pkg::CSR_MSTATUS][3] = 1'b0;
            end
            check_val("global_int_en_o", {31'd0, model[csr_pkg::CSR_MSTATUS][3]},
                      {31'd0, global_int_en_o});
            @(negedge clk);
            #5;
            check_true(!redirect_o && !hold_o, "redirect or hold stuck after sequence");
        end else if (r.irq) begin
            repeat (8) begin
                @(negedge clk);
                #5;
                check_true(!redirect_o && !hold_o, "masked interrupt started a trap");
            end
            irq_i = 1'b0;
        end
        repeat (r.idle) @(negedge clk);
        $display("row %0d op %0d addr %03h irq %0b ecall %0b mret %0b: %s", idx, r.op, r.addr,
                 r.irq, r.ecall, r.mret, row_err == 0 ? "pass" : "fail");
    endtask

    task automatic add_cmd(input csr_pkg::csr_op_e op, input logic [`CSR_AW-1:0] addr,
                           input logic [`XLEN-1:0] operand, input int idle);
        rows.push_back('{op, addr, operand, 1'b0, 1'b0, 1'b0, 32'h0, idle});
    endtask

    task automatic add_event(input logic irq, input logic ecall, input logic mret,
                             input logic [`XLEN-1:0] pc);
        rows.push_back('{csr_pkg::CSR_NONE, 12'h0, 32'h0, irq, ecall, mret, pc, 1});
    endtask

    initial begin
        arst_n_i = 1'b0;
        cmd_i    = '0;
        pc_i     = '0;
        irq_i    = 1'b0;
        ecall_i  = 1'b0;
        mret_i   = 1'b0;
        seed     = 32'h9b885259;
        errors   = 0;
        checks   = 0;
        edges    = 0;
        limit    = 0;
        have_cyc = 1'b0;
        foreach (model[i]) model[i] = '0;

        // reset values and cycle ordering
        add_cmd(csr_pkg::CSR_RS, csr_pkg::CSR_MSTATUS, 32'h0, 0);
        add_cmd(csr_pkg::CSR_RS, csr_pkg::CSR_MIE, 32'h0, 0);
        add_cmd(csr_pkg::CSR_RS, csr_pkg::CSR_MTVEC, 32'h0, 0);
        add_cmd(csr_pkg::CSR_RS, csr_pkg::CSR_MSCRATCH, 32'h0, 0);
        add_cmd(csr_pkg::CSR_RS, csr_pkg::CSR_MEPC, 32'h0, 0);
        add_cmd(csr_pkg::CSR_RS, csr_pkg::CSR_MCAUSE, 32'h0, 0);
        add_cmd(csr_pkg::CSR_RS, csr_pkg::CSR_CYCLE, 32'h0, 3);
        add_cmd(csr_pkg::CSR_RS, csr_pkg::CSR_CYCLE, 32'h0, 0);
        for (int i = 0; i < 2; i++) begin
            add_cmd(csr_pkg::CSR_RW, i ? csr_pkg::CSR_MTVEC : csr_pkg::CSR_MSCRATCH,
                    $random(seed), 0);
            add_cmd(csr_pkg::CSR_RS, i ? csr_pkg::CSR_MTVEC : csr_pkg::CSR_MSCRATCH,
                    $random(seed), 0);
            add_cmd(csr_pkg::CSR_RS, i ? csr_pkg::CSR_MTVEC : csr_pkg::CSR_MSCRATCH, 32'h0, 0);
            add_cmd(csr_pkg::CSR_RC, i ? csr_pkg::CSR_MTVEC : csr_pkg::CSR_MSCRATCH,
                    $random(seed), 0);
            add_cmd(csr_pkg::CSR_RC, i ? csr_pkg::CSR_MTVEC : csr_pkg::CSR_MSCRATCH, 32'h0, 0);
            add_cmd(csr_pkg::CSR_RS, i ? csr_pkg::CSR_MTVEC : csr_pkg::CSR_MSCRATCH, 32'h0, 1);
        end
        // unknown address and read-only counter
        add_cmd(csr_pkg::CSR_RW, 12'h7c0, $random(seed), 0);
        add_cmd(csr_pkg::CSR_RS, 12'h7c0, 32'h0, 0);
        add_cmd(csr_pkg::CSR_RW, csr_pkg::CSR_CYCLE, $random(seed), 2);
        add_cmd(csr_pkg::CSR_RS, csr_pkg::CSR_CYCLE, 32'h0, 0);
        // ecall with interrupts enabled
        add_cmd(csr_pkg::CSR_RW, csr_pkg::CSR_MSTATUS, 32'h8, 0);
        add_event(1'b0, 1'b1, 1'b0, 32'h00001a40);
        add_cmd(csr_pkg::CSR_RS, csr_pkg::CSR_MEPC, 32'h0, 0);
        add_cmd(csr_pkg::CSR_RS, csr_pkg::CSR_MCAUSE, 32'h0, 0);
        add_cmd(csr_pkg::CSR_RS, csr_pkg::CSR_MSTATUS, 32'h0, 0);
        // interrupt gating by mstatus.MIE and mie
        add_event(1'b1, 1'b0, 1'b0, $random(seed));
        add_cmd(csr_pkg::CSR_RS, csr_pkg::CSR_MIE, 32'h800, 0);
        add_event(1'b1, 1'b0, 1'b0, $random(seed));
        add_cmd(csr_pkg::CSR_RS, csr_pkg::CSR_MSTATUS, 32'h8, 0);
        add_cmd(csr_pkg::CSR_RC, csr_pkg::CSR_MIE, 32'h800, 0);
        add_event(1'b1, 1'b0, 1'b0, $random(seed));
        add_cmd(csr_pkg::CSR_RS, csr_pkg::CSR_MIE, 32'h800, 0);
        add_event(1'b1, 1'b0, 1'b0, 32'h20000100);
        add_cmd(csr_pkg::CSR_RS, csr_pkg::CSR_MCAUSE, 32'h0, 0);
        add_cmd(csr_pkg::CSR_RS, csr_pkg::CSR_MEPC, 32'h0, 0);
        // return from the trap
        add_event(1'b0, 1'b0, 1'b1, 32'h0);
        add_cmd(csr_pkg::CSR_RS, csr_pkg::CSR_MSTATUS, 32'h0, 0);
        // return again with MPIE clear
        add_cmd(csr_pkg::CSR_RC, csr_pkg::CSR_MSTATUS, 32'h88, 0);
        add_event(1'b0, 1'b0, 1'b1, 32'h0);
        add_cmd(csr_pkg::CSR_RS, csr_pkg::CSR_MSTATUS, 32'h0, 0);

        foreach (rows[i]) begin
            limit += 2 + rows[i].idle + ((rows[i].irq | rows[i].ecall | rows[i].mret) ? 10 : 0);
        end
        limit += 16 + 100;

        repeat (16) @(negedge clk);
        arst_n_i = 1'b1;
        #5;
        check_true(!hold_o && !redirect_o && !global_int_en_o, "control outputs high after reset");

        foreach (rows[i]) run_row(rows[i], i);

        $display("%0d rows, %0d checks, %0d errors", rows.size(), checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+include
source/csr_pkg.sv
source/csr_alu.sv
source/csr_file.sv
source/trap_ctrl.sv
source/csr_unit_top.sv
test/csr_unit_tb.sv

// File: run.sh
#!/bin/sh
# build and run the csr unit regression with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module csr_unit_tb -f verilog.f \
    -o csr_unit_tb

./obj_dir/csr_unit_tb | tee sim.log

if grep -q "Regression failed" sim.log; then
    exit 1
fi
